/* sys_unit_top.f */
rtl/sys_pkg.sv
rtl/trap_unit.sv
rtl/sys_decode.sv
rtl/csr_file.sv
rtl/sys_commit.sv
rtl/sys_unit_top.sv
tests/tb_sys_unit.sv

/* tests/tb_sys_unit.sv */
// Testbench for the system-instruction unit with directed CSR and trap cases and a random mix
module tb_sys_unit;
  import sys_pkg::*;

  localparam int XLEN       = 64;
  localparam int WAIT_LIMIT = 200;
  localparam logic [2:0] F3_RW  = 3'b001;
  localparam logic [2:0] F3_RS  = 3'b010;
  localparam logic [2:0] F3_RC  = 3'b011;
  localparam logic [2:0] F3_RWI = 3'b101;
  localparam logic [2:0] F3_RSI = 3'b110;
  localparam logic [2:0] F3_RCI = 3'b111;
  localparam logic [XLEN-1:0] MSTATUS_INIT = XLEN'(3) << MSTATUS_MPP_LO;

  typedef struct packed {
    logic            we;
    logic [4:0]      addr;
    logic [XLEN-1:0] data;
    logic            redirect;
    logic [XLEN-1:0] next_pc;
    logic            trap;
    logic [2:0]      test;
  } expect_t;

  logic            i_clk;
  logic            i_rst_n;
  logic            i_valid;
  logic            o_ready;
  logic [31:0]     i_instr;
  logic [XLEN-1:0] i_pc;
  logic [XLEN-1:0] i_rs1_data;
  logic            o_valid;
  logic            i_ready;
  logic            o_rd_we;
  logic [4:0]      o_rd_addr;
  logic [XLEN-1:0] o_rd_data;
  logic            o_redirect;
  logic [XLEN-1:0] o_next_pc;
  logic            o_trap;

  expect_t         exp_q[$];
  expect_t         head;
  logic            head_valid;
  logic            xfer;
  logic            stall_on;
  logic [31:0]     rng;
  logic [XLEN-1:0] issue_pc;
  logic [XLEN-1:0] m_mstatus;
  logic [XLEN-1:0] m_mtvec;
  logic [XLEN-1:0] m_mepc;
  logic [XLEN-1:0] m_mcause;
  logic [XLEN-1:0] m_mscratch;
  int              value_errs;
  int              protocol_errs;

  sys_unit_top #(.XLEN(XLEN)) i_sys_unit_top (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(i_valid), .o_ready(o_ready),
    .i_instr(i_instr), .i_pc(i_pc), .i_rs1_data(i_rs1_data),
    .o_valid(o_valid), .i_ready(i_ready),
    .o_rd_we(o_rd_we), .o_rd_addr(o_rd_addr), .o_rd_data(o_rd_data),
    .o_redirect(o_redirect), .o_next_pc(o_next_pc), .o_trap(o_trap)
  );

  always #2 i_clk = ~i_clk;

  assign xfer = o_valid && i_ready;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "csrrw";
      2:       return "csrrs_csrrc";
      3:       return "ecall";
      4:       return "mret";
      5:       return "illegal";
      default: return "random_mix";
    endcase
  endfunction

  function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] csr,
                                            input logic [4:0] src, input logic [4:0] rd);
    return {csr, src, f3, rd, OPC_SYSTEM};
  endfunction

  task automatic value_error(input string field, input int test, input logic [XLEN-1:0] exp_v,
                             input logic [XLEN-1:0] act_v);
    value_errs++;
    $display("Error: %s %s expected %h actual %h", test_name(test), field, exp_v, act_v);
  endtask

  task automatic refresh_head();
    head_valid = (exp_q.size() > 0);
    if (head_valid) begin
      head = exp_q[0];
    end
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Errors: %0d value mismatches, %0d protocol errors", value_errs, protocol_errs);
    $display("Test failed");
    $finish;
  endtask

  // Reference model of the machine CSRs that runs in program order at issue time
  task automatic model_issue(input logic [31:0] word, input logic [XLEN-1:0] pc,
                             input logic [XLEN-1:0] rs1, input int test);
    instr_u          w;
    expect_t         e;
    logic [XLEN-1:0] old_v;
    logic [XLEN-1:0] operand;
    logic [XLEN-1:0] new_v;
    logic            is_csr;
    logic            ecall;
    logic            mret;
    logic            illegal;
    logic            trap;
    logic            plain;
    w       = word;
    is_csr  = 1'b0;
    ecall   = 1'b0;
    mret    = 1'b0;
    illegal = 1'b0;
    old_v   = '0;
    plain   = (w.priv.rs1 == 5'd0) && (w.priv.rd == 5'd0);
    if (w.csr.opcode != OPC_SYSTEM) begin
      illegal = 1'b1;
    end else if (w.priv.funct3 == 3'b000) begin
      if (plain && {w.priv.funct7, w.priv.rs2} == F12_ECALL) ecall = 1'b1;
      else if (plain && {w.priv.funct7, w.priv.rs2} == F12_MRET) mret = 1'b1;
      else illegal = 1'b1;
    end else if (w.csr.funct3[1:0] == 2'b00) begin
      illegal = 1'b1;
    end else begin
      is_csr = 1'b1;
      case (w.csr.csr)
        CSR_MSTATUS:  old_v = m_mstatus;
        CSR_MTVEC:    old_v = m_mtvec;
        CSR_MSCRATCH: old_v = m_mscratch;
        CSR_MEPC:     old_v = m_mepc;
        CSR_MCAUSE:   old_v = m_mcause;
        default:      illegal = 1'b1;
      endcase
    end
    operand = w.csr.funct3[2] ? XLEN'(w.csr.src) : rs1;
    case (w.csr.funct3[1:0])
      2'b01:   new_v = operand;
      2'b10:   new_v = old_v | operand;
      default: new_v = old_v & ~operand;
    endcase
    trap       = illegal || ecall;
    e.we       = !trap && (w.csr.rd != 5'd0);
    e.addr     = w.csr.rd;
    e.data     = old_v;
    e.redirect = trap || mret;
    e.next_pc  = trap ? m_mtvec : (mret ? m_mepc : pc + XLEN'(4));
    e.trap     = trap;
    e.test     = 3'(test);
    if (trap) begin
      m_mepc                  = pc;
      m_mcause                = illegal ? XLEN'(CAUSE_ILLEGAL) : XLEN'(CAUSE_ECALL_M);
      m_mstatus[MSTATUS_MPIE] = m_mstatus[MSTATUS_MIE];
      m_mstatus[MSTATUS_MIE]  = 1'b0;
    end else if (mret) begin
      m_mstatus[MSTATUS_MIE]  = m_mstatus[MSTATUS_MPIE];
      m_mstatus[MSTATUS_MPIE] = 1'b1;
    end else if (is_csr && (w.csr.funct3[1:0] == 2'b01 || w.csr.src != 5'd0)) begin
      case (w.csr.csr)
        CSR_MSTATUS: begin
          m_mstatus               = MSTATUS_INIT;
          m_mstatus[MSTATUS_MIE]  = new_v[MSTATUS_MIE];
          m_mstatus[MSTATUS_MPIE] = new_v[MSTATUS_MPIE];
        end
        CSR_MTVEC:    m_mtvec    = {new_v[XLEN-1:2], 2'b00};
        CSR_MEPC:     m_mepc     = {new_v[XLEN-1:2], 2'b00};
        CSR_MCAUSE:   m_mcause   = new_v;
        CSR_MSCRATCH: m_mscratch = new_v;
        default: ;
      endcase
    end
    exp_q.push_back(e);
    refresh_head();
  endtask

  // Moves to the next falling edge and sets the downstream ready for that cycle
  task automatic tick();
    @(negedge i_clk);
    rng     = lcg_step(rng);
    i_ready = stall_on ? (rng[31:30] != 2'b00) : 1'b1;
  endtask

  task automatic send(input logic [31:0] word, input logic [XLEN-1:0] rs1, input int test);
    int waited;
    model_issue(word, issue_pc, rs1, test);
    i_valid    = 1'b1;
    i_instr    = word;
    i_pc       = issue_pc;
    i_rs1_data = rs1;
    issue_pc   = issue_pc + XLEN'(4);
    waited     = 0;
    #1;
    while (!o_ready && waited < WAIT_LIMIT) begin
      tick();
      #1;
      waited++;
    end
    if (!o_ready) abort_run("the DUT stopped accepting instructions");
    tick();
    i_valid = 1'b0;
  endtask

  task automatic drain(input int test);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      tick();
      waited++;
    end
    if (exp_q.size() != 0) abort_run({"results of ", test_name(test), " never came out"});
  endtask

  function automatic logic [11:0] pick_csr(input int n);
    case (n % 6)
      0:       return CSR_MSTATUS;
      1:       return CSR_MTVEC;
      2:       return CSR_MSCRATCH;
      3:       return CSR_MEPC;
      4:       return CSR_MCAUSE;
      default: return 12'h7c0;
    endcase
  endfunction

  task automatic send_random();
    logic [31:0]     word;
    logic [XLEN-1:0] rs1;
    logic [4:0]      src;
    logic [2:0]      f3;
    rng = lcg_step(rng);
    if (rng[31:30] == 2'b00) tick();
    rng = lcg_step(rng);
    rs1[XLEN-1:32] = rng;
    rng = lcg_step(rng);
    rs1[31:0] = rng;
    rng = lcg_step(rng);
    src = (rng[23:22] == 2'b00) ? 5'd0 : rng[20:16];
    case (rng[31:28] % 6)
      0:       f3 = F3_RW;
      1:       f3 = F3_RS;
      2:       f3 = F3_RC;
      3:       f3 = F3_RWI;
      4:       f3 = F3_RSI;
      default: f3 = F3_RCI;
    endcase
    word = csr_instr(f3, pick_csr(int'(rng[27:24])), src, rng[11:7]);
    rng = lcg_step(rng);
    if (rng[31:28] inside {4'd12, 4'd13}) word = 32'h0000_0073;
    else if (rng[31:28] == 4'd14) word = 32'h3020_0073;
    else if (rng[31:28] == 4'd15) word[6:0] = 7'b0110011;
    send(word, rs1, 6);
  endtask

  always @(posedge i_clk) begin
    if (i_rst_n && xfer && head_valid) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  a_no_extra: assert property (@(posedge i_clk) disable iff (!i_rst_n) xfer |-> head_valid)
    else begin
      protocol_errs++;
      $display("An output appeared with no instruction outstanding");
    end
  a_rd_we: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    xfer && head_valid |-> o_rd_we == head.we)
    else value_error("rd_we", $sampled(head.test), $sampled(head.we), $sampled(o_rd_we));
  a_rd_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    xfer && head_valid |-> o_rd_addr == head.addr)
    else value_error("rd_addr", $sampled(head.test), $sampled(head.addr), $sampled(o_rd_addr));
  a_rd_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    xfer && head_valid && head.we |-> o_rd_data == head.data)
    else value_error("rd_data", $sampled(head.test), $sampled(head.data), $sampled(o_rd_data));
  a_redirect: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    xfer && head_valid |-> o_redirect == head.redirect)
    else value_error("redirect", $sampled(head.test), $sampled(head.redirect),
                     $sampled(o_redirect));
  a_next_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    xfer && head_valid |-> o_next_pc == head.next_pc)
    else value_error("next_pc", $sampled(head.test), $sampled(head.next_pc), $sampled(o_next_pc));
  a_trap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    xfer && head_valid |-> o_trap == head.trap)
    else value_error("trap", $sampled(head.test), $sampled(head.trap), $sampled(o_trap));

  initial begin
    i_clk         = 1'b0;
    i_rst_n       = 1'b0;
    i_valid       = 1'b0;
    i_ready       = 1'b1;
    i_instr       = '0;
    i_pc          = '0;
    i_rs1_data    = '0;
    stall_on      = 1'b0;
    rng           = 32'd60122;
    issue_pc      = XLEN'(32'h0000_1000);
    m_mstatus     = MSTATUS_INIT;
    m_mtvec       = '0;
    m_mepc        = '0;
    m_mcause      = '0;
    m_mscratch    = '0;
    head          = '0;
    head_valid    = 1'b0;
    value_errs    = 0;
    protocol_errs = 0;
    repeat (8) @(negedge i_clk);
    i_rst_n = 1'b1;
    #1;
    assert (!o_valid && o_ready) else begin
      protocol_errs++;
      $display("The DUT is not idle and ready after reset");
    end
    @(negedge i_clk);

    send(csr_instr(F3_RW, CSR_MSCRATCH, 5'd1, 5'd5), 64'h1234_5678_9abc_def0, 1);
    send(csr_instr(F3_RW, CSR_MSCRATCH, 5'd2, 5'd6), 64'h0f0f_0000_ffff_0001, 1);
    send(csr_instr(F3_RWI, CSR_MTVEC, 5'h13, 5'd7), '0, 1);
    send(csr_instr(F3_RW, CSR_MTVEC, 5'd3, 5'd8), 64'h8000_1003, 1);
    send(csr_instr(F3_RS, CSR_MTVEC, 5'd0, 5'd9), '1, 1);
    send(csr_instr(F3_RWI, CSR_MSCRATCH, 5'd9, 5'd10), '0, 1);
    drain(1);

    send(csr_instr(F3_RS, CSR_MSCRATCH, 5'd1, 5'd11), 64'hf0, 2);
    send(csr_instr(F3_RC, CSR_MSCRATCH, 5'd2, 5'd12), 64'h09, 2);
    send(csr_instr(F3_RSI, CSR_MSCRATCH, 5'd0, 5'd13), '0, 2);
    send(csr_instr(F3_RCI, CSR_MSCRATCH, 5'd0, 5'd14), '0, 2);
    send(csr_instr(F3_RW, CSR_MSCRATCH, 5'd3, 5'd0), 64'h55, 2);
    send(csr_instr(F3_RS, CSR_MSCRATCH, 5'd0, 5'd15), '1, 2);
    send(csr_instr(F3_RS, CSR_MSTATUS, 5'd1, 5'd16), '1, 2);
    send(csr_instr(F3_RS, CSR_MSTATUS, 5'd0, 5'd17), '0, 2);
    send(csr_instr(F3_RCI, CSR_MSTATUS, 5'd8, 5'd18), '0, 2);
    send(csr_instr(F3_RW, CSR_MSTATUS, 5'd1, 5'd19), '0, 2);
    send(csr_instr(F3_RSI, CSR_MSTATUS, 5'd8, 5'd0), '0, 2);
    drain(2);

    send(32'h0000_0073, '0, 3);
    send(csr_instr(F3_RS, CSR_MEPC, 5'd0, 5'd1), '0, 3);
    send(csr_instr(F3_RS, CSR_MCAUSE, 5'd0, 5'd2), '0, 3);
    send(csr_instr(F3_RS, CSR_MSTATUS, 5'd0, 5'd3), '0, 3);
    drain(3);

    send(32'h3020_0073, '0, 4);
    send(csr_instr(F3_RS, CSR_MSTATUS, 5'd0, 5'd4), '0, 4);
    send(csr_instr(F3_RW, CSR_MEPC, 5'd1, 5'd5), 64'h4006, 4);
    // With MIE and MPIE both clear, mret must copy the zero and then set MPIE
    send(csr_instr(F3_RC, CSR_MSTATUS, 5'd2, 5'd0), 64'h88, 4);
    send(32'h3020_0073, '0, 4);
    send(csr_instr(F3_RS, CSR_MSTATUS, 5'd0, 5'd6), '0, 4);
    drain(4);

    send(csr_instr(F3_RW, 12'h7c0, 5'd1, 5'd7), 64'h77, 5);
    send({CSR_MSCRATCH, 5'd1, 3'b100, 5'd8, OPC_SYSTEM}, 64'h1, 5);
    send(32'h0020_81b3, '0, 5);
    send(csr_instr(F3_RS, CSR_MCAUSE, 5'd0, 5'd9), '0, 5);
    send(csr_instr(F3_RS, CSR_MEPC, 5'd0, 5'd10), '0, 5);
    drain(5);

    // Random stalls on the output fill the pipeline and push back on the input
    stall_on = 1'b1;
    repeat (400) send_random();
    drain(6);
    stall_on = 1'b0;
    repeat (4) tick();

    $display("Errors: %0d value mismatches, %0d protocol errors", value_errs, protocol_errs);
    if (value_errs == 0 && protocol_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* rtl/sys_unit_top.sv */
// System-instruction unit that chains decode, CSR access and commit as a three-stage pipeline
module sys_unit_top #(
  parameter int XLEN = 64
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_valid,
  output logic            o_ready,
  input  logic [31:0]     i_instr,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1_data,
  output logic            o_valid,
  input  logic            i_ready,
  output logic            o_rd_we,
  output logic [4:0]      o_rd_addr,
  output logic [XLEN-1:0] o_rd_data,
  output logic            o_redirect,
  output logic [XLEN-1:0] o_next_pc,
  output logic            o_trap
);
  import sys_pkg::*;

  logic            d_valid;
  logic            d_ready;
  logic [OP_W-1:0] d_op;
  logic [11:0]     d_csr_addr;
  logic [XLEN-1:0] d_operand;
  logic            d_csr_write;
  logic [4:0]      d_rd;
  logic [XLEN-1:0] d_pc;
  logic            d_illegal;

  logic            x_valid;
  logic            x_ready;
  logic [4:0]      x_rd;
  logic [XLEN-1:0] x_old_value;
  logic            x_trap;
  logic            x_redirect;
  logic [XLEN-1:0] x_target;
  logic [XLEN-1:0] x_pc;

  sys_decode #(.XLEN(XLEN)) i_sys_decode (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(i_valid), .o_ready(o_ready),
    .i_instr(i_instr), .i_pc(i_pc), .i_rs1_data(i_rs1_data),
    .o_valid(d_valid), .i_ready(d_ready),
    .o_op(d_op), .o_csr_addr(d_csr_addr), .o_operand(d_operand),
    .o_csr_write(d_csr_write), .o_rd(d_rd), .o_pc(d_pc), .o_illegal(d_illegal)
  );

  csr_file #(.XLEN(XLEN)) i_csr_file (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(d_valid), .o_ready(d_ready),
    .i_op(d_op), .i_csr_addr(d_csr_addr), .i_operand(d_operand),
    .i_csr_write(d_csr_write), .i_rd(d_rd), .i_pc(d_pc), .i_illegal(d_illegal),
    .o_valid(x_valid), .i_ready(x_ready),
    .o_rd(x_rd), .o_old_value(x_old_value), .o_trap(x_trap),
    .o_redirect(x_redirect), .o_target(x_target), .o_pc(x_pc)
  );

  sys_commit #(.XLEN(XLEN)) i_sys_commit (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_valid(x_valid), .o_ready(x_ready),
    .i_rd(x_rd), .i_old_value(x_old_value), .i_trap(x_trap),
    .i_redirect(x_redirect), .i_target(x_target), .i_pc(x_pc),
    .o_valid(o_valid), .i_ready(i_ready),
    .o_rd_we(o_rd_we), .o_rd_addr(o_rd_addr), .o_rd_data(o_rd_data),
    .o_redirect(o_redirect), .o_next_pc(o_next_pc), .o_trap(o_trap)
  );

endmodule

/* rtl/sys_commit.sv */
// Commit stage that forms the register writeback and next pc in the output register
module sys_commit #(
  parameter int XLEN = 64
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_valid,
  output logic            o_ready,
  input  logic [4:0]      i_rd,
  input  logic [XLEN-1:0] i_old_value,
  input  logic            i_trap,
  input  logic            i_redirect,
  input  logic [XLEN-1:0] i_target,
  input  logic [XLEN-1:0] i_pc,
  output logic            o_valid,
  input  logic            i_ready,
  output logic            o_rd_we,
  output logic [4:0]      o_rd_addr,
  output logic [XLEN-1:0] o_rd_data,
  output logic            o_redirect,
  output logic [XLEN-1:0] o_next_pc,
  output logic            o_trap
);

  logic take;

  assign o_ready = !o_valid || i_ready;
  assign take    = i_valid && o_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid    <= 1'b0;
      o_rd_we    <= 1'b0;
      o_redirect <= 1'b0;
      o_trap     <= 1'b0;
    end else if (take) begin
      o_valid    <= 1'b1;
      // x0 is never written, and a trapping instruction retires nothing
      o_rd_we    <= !i_trap && (i_rd != 5'd0);
      o_redirect <= i_redirect;
      o_trap     <= i_trap;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      o_rd_addr <= i_rd;
      o_rd_data <= i_old_value;
      o_next_pc <= i_redirect ? i_target : i_pc + XLEN'(4);
    end
  end

  a_no_we_on_trap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_rd_we && o_trap));

endmodule

/* rtl/csr_file.sv */
// CSR stage holding the machine CSRs, doing the read-modify-write and the trap state update
module csr_file #(
  parameter int XLEN = 64
) (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_valid,
  output logic                     o_ready,
  input  logic [sys_pkg::OP_W-1:0] i_op,
  input  logic [11:0]              i_csr_addr,
  input  logic [XLEN-1:0]          i_operand,
  input  logic                     i_csr_write,
  input  logic [4:0]               i_rd,
  input  logic [XLEN-1:0]          i_pc,
  input  logic                     i_illegal,
  output logic                     o_valid,
  input  logic                     i_ready,
  output logic [4:0]               o_rd,
  output logic [XLEN-1:0]          o_old_value,
  output logic                     o_trap,
  output logic                     o_redirect,
  output logic [XLEN-1:0]          o_target,
  output logic [XLEN-1:0]          o_pc
);
  import sys_pkg::*;

  localparam logic [XLEN-1:0] MSTATUS_WMASK =
    (XLEN'(1) << MSTATUS_MIE) | (XLEN'(1) << MSTATUS_MPIE);
  localparam logic [XLEN-1:0] MSTATUS_RESET = XLEN'(MPP_MACHINE) << MSTATUS_MPP_LO;
  localparam logic [XLEN-1:0] ALIGN_MASK    = ~XLEN'(3);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] mscratch;

  logic [XLEN-1:0] rd_value;
  logic [XLEN-1:0] wr_value;
  logic            addr_known;
  logic            is_csr_op;
  logic            illegal_any;
  logic            take;
  logic            take_trap;
  logic            tu_redirect;
  logic [XLEN-1:0] cause;
  logic [XLEN-1:0] mstatus_next;
  logic [XLEN-1:0] target;

  always_comb begin
    addr_known = 1'b1;
    case (i_csr_addr)
      CSR_MSTATUS:  rd_value = mstatus;
      CSR_MTVEC:    rd_value = mtvec;
      CSR_MSCRATCH: rd_value = mscratch;
      CSR_MEPC:     rd_value = mepc;
      CSR_MCAUSE:   rd_value = mcause;
      default: begin
        rd_value   = '0;
        addr_known = 1'b0;
      end
    endcase
  end

  assign is_csr_op   = (i_op == OP_CSRRW) || (i_op == OP_CSRRS) || (i_op == OP_CSRRC);
  assign illegal_any = i_illegal || (is_csr_op && !addr_known);

  always_comb begin
    case (i_op)
      OP_CSRRS: wr_value = rd_value | i_operand;
      OP_CSRRC: wr_value = rd_value & ~i_operand;
      default:  wr_value = i_operand;
    endcase
  end

  trap_unit #(
    .XLEN(XLEN)
  ) i_trap_unit (
    .i_op           (i_op),
    .i_illegal      (illegal_any),
    .i_pc           (i_pc),
    .i_mstatus      (mstatus),
    .i_mtvec        (mtvec),
    .i_mepc         (mepc),
    .o_take_trap    (take_trap),
    .o_cause        (cause),
    .o_mstatus_next (mstatus_next),
    .o_redirect     (tu_redirect),
    .o_target       (target)
  );

  assign o_ready = !o_valid || i_ready;
  assign take    = i_valid && o_ready;

  // The CSRs change only at the transfer into commit, which keeps program order
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mstatus  <= MSTATUS_RESET;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else if (take) begin
      if (take_trap) begin
        mepc    <= i_pc & ALIGN_MASK;
        mcause  <= cause;
        mstatus <= mstatus_next;
      end else if (i_op == OP_MRET) begin
        mstatus <= mstatus_next;
      end else if (i_csr_write) begin
        case (i_csr_addr)
          CSR_MSTATUS:  mstatus  <= (wr_value & MSTATUS_WMASK) | MSTATUS_RESET;
          CSR_MTVEC:    mtvec    <= wr_value & ALIGN_MASK;
          CSR_MSCRATCH: mscratch <= wr_value;
          CSR_MEPC:     mepc     <= wr_value & ALIGN_MASK;
          CSR_MCAUSE:   mcause   <= wr_value;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (take) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      o_rd        <= i_rd;
      o_old_value <= rd_value;
      o_trap      <= take_trap;
      o_redirect  <= tu_redirect;
      o_target    <= target;
      o_pc        <= i_pc;
    end
  end

  a_csr_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !take |=> $stable({mstatus, mtvec, mepc, mcause, mscratch}));

endmodule

/* rtl/sys_decode.sv */
// Decode stage that turns a SYSTEM instruction word into operation, CSR address and operand
module sys_decode #(
  parameter int XLEN = 64
) (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_valid,
  output logic                     o_ready,
  input  sys_pkg::instr_u          i_instr,
  input  logic [XLEN-1:0]          i_pc,
  input  logic [XLEN-1:0]          i_rs1_data,
  output logic                     o_valid,
  input  logic                     i_ready,
  output logic [sys_pkg::OP_W-1:0] o_op,
  output logic [11:0]              o_csr_addr,
  output logic [XLEN-1:0]          o_operand,
  output logic                     o_csr_write,
  output logic [4:0]               o_rd,
  output logic [XLEN-1:0]          o_pc,
  output logic                     o_illegal
);
  import sys_pkg::*;

  logic [OP_W-1:0] dec_op;
  logic [XLEN-1:0] dec_operand;
  logic            dec_write;
  logic            dec_illegal;
  logic [11:0]     funct12;
  logic            src_nonzero;
  logic            take;

  assign funct12     = {i_instr.priv.funct7, i_instr.priv.rs2};
  assign src_nonzero = (i_instr.csr.src != 5'd0);

  always_comb begin
    dec_op      = OP_CSRRW;
    dec_write   = 1'b0;
    dec_illegal = 1'b0;
    // funct3[2] picks the zero-extended uimm over rs1
    dec_operand = i_instr.csr.funct3[2] ? XLEN'(i_instr.csr.src) : i_rs1_data;
    if (i_instr.csr.opcode != OPC_SYSTEM) begin
      dec_illegal = 1'b1;
    end else if (i_instr.priv.funct3 == 3'b000) begin
      if (i_instr.priv.rs1 != 5'd0 || i_instr.priv.rd != 5'd0) begin
        dec_illegal = 1'b1;
      end else if (funct12 == F12_ECALL) begin
        dec_op = OP_ECALL;
      end else if (funct12 == F12_MRET) begin
        dec_op = OP_MRET;
      end else begin
        dec_illegal = 1'b1;
      end
    end else begin
      case (i_instr.csr.funct3[1:0])
        2'b01: begin
          dec_op    = OP_CSRRW;
          dec_write = 1'b1;
        end
        2'b10: begin
          dec_op    = OP_CSRRS;
          dec_write = src_nonzero;
        end
        2'b11: begin
          dec_op    = OP_CSRRC;
          dec_write = src_nonzero;
        end
        default: dec_illegal = 1'b1;
      endcase
    end
  end

  assign o_ready = !o_valid || i_ready;
  assign take    = i_valid && o_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (take) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      o_op        <= dec_op;
      o_csr_addr  <= i_instr.csr.csr;
      o_operand   <= dec_operand;
      o_csr_write <= dec_write;
      o_rd        <= i_instr.csr.rd;
      o_pc        <= i_pc;
      o_illegal   <= dec_illegal;
    end
  end

  // A stalled instruction must not change under the CSR stage
  a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_valid && !i_ready |=> o_valid &&
      $stable({o_op, o_csr_addr, o_operand, o_csr_write, o_rd, o_pc, o_illegal}));

endmodule

/* rtl/trap_unit.sv */
// Trap unit giving cause, next mstatus, redirect and target for ecall, illegal and mret
module trap_unit #(
  parameter int XLEN = 64
) (
  input  logic [sys_pkg::OP_W-1:0] i_op,
  input  logic                     i_illegal,
  input  logic [XLEN-1:0]          i_pc,
  input  logic [XLEN-1:0]          i_mstatus,
  input  logic [XLEN-1:0]          i_mtvec,
  input  logic [XLEN-1:0]          i_mepc,
  output logic                     o_take_trap,
  output logic [XLEN-1:0]          o_cause,
  output logic [XLEN-1:0]          o_mstatus_next,
  output logic                     o_redirect,
  output logic [XLEN-1:0]          o_target
);
  import sys_pkg::*;

  logic is_mret;

  // Illegal wins over whatever the op field says
  assign o_take_trap = i_illegal || (i_op == OP_ECALL);
  assign is_mret     = !i_illegal && (i_op == OP_MRET);
  assign o_redirect  = o_take_trap || is_mret;

  assign o_cause = i_illegal ? XLEN'(CAUSE_ILLEGAL) : XLEN'(CAUSE_ECALL_M);

  always_comb begin
    o_mstatus_next = i_mstatus;
    if (o_take_trap) begin
      o_mstatus_next[MSTATUS_MPIE] = i_mstatus[MSTATUS_MIE];
      o_mstatus_next[MSTATUS_MIE]  = 1'b0;
    end else if (is_mret) begin
      o_mstatus_next[MSTATUS_MIE]  = i_mstatus[MSTATUS_MPIE];
      o_mstatus_next[MSTATUS_MPIE] = 1'b1;
    end
  end

  // Without a redirect the target is simply the next sequential pc
  always_comb begin
    if (o_take_trap) begin
      o_target = i_mtvec;
    end else if (is_mret) begin
      o_target = i_mepc;
    end else begin
      o_target = i_pc + XLEN'(4);
    end
  end

endmodule

/* rtl/sys_pkg.sv */
// System-instruction package holding the CSR map, codes, mstatus layout and instruction views
package sys_pkg;

  // Machine CSR addresses
  parameter logic [11:0] CSR_MSTATUS  = 12'h300;
  parameter logic [11:0] CSR_MTVEC    = 12'h305;
  parameter logic [11:0] CSR_MSCRATCH = 12'h340;
  parameter logic [11:0] CSR_MEPC     = 12'h341;
  parameter logic [11:0] CSR_MCAUSE   = 12'h342;

  // Internal operation codes shared by the register and immediate forms
  parameter int OP_W = 3;
  parameter logic [OP_W-1:0] OP_CSRRW = 3'd1;
  parameter logic [OP_W-1:0] OP_CSRRS = 3'd2;
  parameter logic [OP_W-1:0] OP_CSRRC = 3'd3;
  parameter logic [OP_W-1:0] OP_ECALL = 3'd4;
  parameter logic [OP_W-1:0] OP_MRET  = 3'd5;

  parameter logic [6:0]  OPC_SYSTEM = 7'b1110011;
  parameter logic [11:0] F12_ECALL  = 12'h000;
  parameter logic [11:0] F12_MRET   = 12'h302;

  // Exception codes that are widened to XLEN where they are used
  parameter int CAUSE_ILLEGAL = 2;
  parameter int CAUSE_ECALL_M = 11;

  // mstatus fields
  parameter int MSTATUS_MIE    = 3;
  parameter int MSTATUS_MPIE   = 7;
  parameter int MSTATUS_MPP_LO = 11;

  // Only M-mode exists, so MPP is fixed at this value
  parameter logic [1:0] MPP_MACHINE = 2'b11;

  typedef struct packed {
    logic [11:0] csr;
    logic [4:0]  src;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } csr_view_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } priv_view_t;

  typedef union packed {
    csr_view_t  csr;
    priv_view_t priv;
  } instr_u;

endpackage
